/* include/pipe_defs.svh */
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// Datapath and register file geometry.
`define PIPE_XLEN      32
`define PIPE_NREGS     32
`define PIPE_REG_BITS  5

// RV32I major opcodes handled by the slice.
`define OPC_OP         7'b0110011
`define OPC_OP_IMM     7'b0010011
`define OPC_LUI        7'b0110111

// funct3 codes shared by the OP and OP-IMM groups.
`define F3_ADD         3'b000
`define F3_SLL         3'b001
`define F3_SLT         3'b010
`define F3_SLTU        3'b011
`define F3_XOR         3'b100
`define F3_SR          3'b101
`define F3_OR          3'b110
`define F3_AND         3'b111

`endif

/* logic/pipe_pkg.sv */
package pipe_pkg;

  // ##########################################################
  // ALU operations
  // ##########################################################

  typedef enum logic [3:0] {
    ALU_NOP    = 4'd0,   // Bubble value.
    ALU_ADD    = 4'd1,
    ALU_SUB    = 4'd2,
    ALU_AND    = 4'd3,
    ALU_OR     = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SLT    = 4'd6,   // Signed compare.
    ALU_SLTU   = 4'd7,   // Unsigned compare.
    ALU_SLL    = 4'd8,
    ALU_SRL    = 4'd9,
    ALU_SRA    = 4'd10,
    ALU_PASS_B = 4'd11   // Operand B straight through, for LUI.
  } alu_op_e;

  // ##########################################################
  // Issue handshake states
  // ##########################################################

  typedef enum logic [1:0] {
    CTRL_IDLE    = 2'd0,  // Waiting for instr_req.
    CTRL_ACK     = 2'd1,  // Ack high, waiting for req to drop.
    CTRL_RELEASE = 2'd2   // Ack low again, one recovery cycle.
  } ctrl_state_e;

endpackage

/* logic/pipeline_control.sv */
`timescale 1ns/10ps
`include "pipe_defs.svh"

module pipeline_control (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  instr_req,
  input  logic [`PIPE_XLEN-1:0] instr,
  output logic                  instr_ack,
  output logic [`PIPE_XLEN-1:0] held_instr,
  output logic                  issue_valid
);
  import pipe_pkg::*;

  ctrl_state_e state;

  // ##########################################################
  // Four-phase issue FSM
  // ##########################################################

  always_ff @(posedge clock) begin
    if (rst) begin
      state       <= CTRL_IDLE;
      instr_ack   <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= 1'b0; // Single-cycle pulse.
      case (state)
        CTRL_IDLE: begin
          if (instr_req) begin
            instr_ack   <= 1'b1;
            issue_valid <= 1'b1;
            state       <= CTRL_ACK;
          end
        end
        CTRL_ACK: begin
          if (!instr_req) begin
            instr_ack <= 1'b0;
            state     <= CTRL_RELEASE;
          end
        end
        CTRL_RELEASE: state <= CTRL_IDLE;
        default:      state <= CTRL_IDLE;
      endcase
    end
  end

  // Word stays put for decode until the next issue.
  always_ff @(posedge clock) begin
    if (state == CTRL_IDLE && instr_req) begin
      held_instr <= instr;
    end
  end

  ack_only_on_req: assert property (@(posedge clock) disable iff (rst)
    $rose(instr_ack) |-> $past(instr_req));

  issue_is_single: assert property (@(posedge clock) disable iff (rst)
    issue_valid |=> !issue_valid);

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/10ps
`include "pipe_defs.svh"

module instr_decoder (
  input  logic [`PIPE_XLEN-1:0]     instr,
  output logic [`PIPE_REG_BITS-1:0] rs1,
  output logic [`PIPE_REG_BITS-1:0] rs2,
  output logic [`PIPE_REG_BITS-1:0] rd,
  output logic [`PIPE_XLEN-1:0]     imm,
  output pipe_pkg::alu_op_e         alu_op,
  output logic                      use_imm,
  output logic                      reg_write,
  output logic                      illegal
);
  import pipe_pkg::*;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA.

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Register fields sit in fixed positions for every format.
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  always_comb begin
    imm       = '0;
    alu_op    = ALU_NOP;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    case (opcode)
      `OPC_OP: begin
        case (funct3)
          `F3_ADD:  alu_op = (funct7 == F7_BASE) ? ALU_ADD :
                             (funct7 == F7_ALT)  ? ALU_SUB : ALU_NOP;
          `F3_SR:   alu_op = (funct7 == F7_BASE) ? ALU_SRL :
                             (funct7 == F7_ALT)  ? ALU_SRA : ALU_NOP;
          `F3_SLL:  alu_op = (funct7 == F7_BASE) ? ALU_SLL  : ALU_NOP;
          `F3_SLT:  alu_op = (funct7 == F7_BASE) ? ALU_SLT  : ALU_NOP;
          `F3_SLTU: alu_op = (funct7 == F7_BASE) ? ALU_SLTU : ALU_NOP;
          `F3_XOR:  alu_op = (funct7 == F7_BASE) ? ALU_XOR  : ALU_NOP;
          `F3_OR:   alu_op = (funct7 == F7_BASE) ? ALU_OR   : ALU_NOP;
          `F3_AND:  alu_op = (funct7 == F7_BASE) ? ALU_AND  : ALU_NOP;
          default:  alu_op = ALU_NOP;
        endcase
      end
      `OPC_OP_IMM: begin
        imm     = {{20{instr[31]}}, instr[31:20]}; // I-type, sign extended.
        use_imm = 1'b1;
        case (funct3)
          `F3_ADD: alu_op = ALU_ADD;
          `F3_SLT: alu_op = ALU_SLT;
          `F3_XOR: alu_op = ALU_XOR;
          `F3_OR:  alu_op = ALU_OR;
          `F3_AND: alu_op = ALU_AND;
          `F3_SLL: alu_op = (funct7 == F7_BASE) ? ALU_SLL : ALU_NOP;
          `F3_SR:  alu_op = (funct7 == F7_BASE) ? ALU_SRL :
                            (funct7 == F7_ALT)  ? ALU_SRA : ALU_NOP;
          default: alu_op = ALU_NOP; // SLTIU is not supported.
        endcase
      end
      `OPC_LUI: begin
        imm     = {instr[31:12], 12'b0}; // U-type.
        use_imm = 1'b1;
        alu_op  = ALU_PASS_B;
      end
      default: alu_op = ALU_NOP;
    endcase

    // Every supported encoding maps to a real ALU op.
    illegal   = (alu_op == ALU_NOP);
    reg_write = !illegal;
    if (illegal) begin
      imm     = '0;
      use_imm = 1'b0;
    end
  end

endmodule

/* logic/register_file.sv */
`timescale 1ns/10ps
`include "pipe_defs.svh"

module register_file (
  input  logic                      clock,
  input  logic                      rst,
  input  logic [`PIPE_REG_BITS-1:0] rs1,
  input  logic [`PIPE_REG_BITS-1:0] rs2,
  output logic [`PIPE_XLEN-1:0]     rs1_data,
  output logic [`PIPE_XLEN-1:0]     rs2_data,
  input  logic                      wr_en,
  input  logic [`PIPE_REG_BITS-1:0] wr_addr,
  input  logic [`PIPE_XLEN-1:0]     wr_data
);

  logic [`PIPE_XLEN-1:0] regs [`PIPE_NREGS];

  // ##########################################################
  // Write port
  // ##########################################################

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < `PIPE_NREGS; i++) begin
        regs[i] <= '0; // Architectural state starts at zero.
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Read ports, x0 always zero.
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  x0_stays_zero: assert property (@(posedge clock) disable iff (rst)
    regs[0] == '0);

endmodule

/* logic/id_ex_stage_reg.sv */
`timescale 1ns/10ps
`include "pipe_defs.svh"

module id_ex_stage_reg (
  input  logic                      clock,
  input  logic                      rst,
  input  logic                      issue_valid,
  input  logic [`PIPE_XLEN-1:0]     id_rs1_data,
  input  logic [`PIPE_XLEN-1:0]     id_rs2_data,
  input  logic [`PIPE_XLEN-1:0]     id_imm,
  input  logic [`PIPE_REG_BITS-1:0] id_rd,
  input  pipe_pkg::alu_op_e         id_alu_op,
  input  logic                      id_use_imm,
  input  logic                      id_reg_write,
  input  logic                      id_illegal,
  output logic [`PIPE_XLEN-1:0]     ex_rs1_data,
  output logic [`PIPE_XLEN-1:0]     ex_rs2_data,
  output logic [`PIPE_XLEN-1:0]     ex_imm,
  output logic [`PIPE_REG_BITS-1:0] ex_rd,
  output pipe_pkg::alu_op_e         ex_alu_op,
  output logic                      ex_use_imm,
  output logic                      ex_reg_write,
  output logic                      ex_illegal
);
  import pipe_pkg::*;

  always_ff @(posedge clock) begin
    if (rst || !issue_valid) begin
      ex_rs1_data  <= '0; // Bubble.
      ex_rs2_data  <= '0;
      ex_imm       <= '0;
      ex_rd        <= '0;
      ex_alu_op    <= ALU_NOP;
      ex_use_imm   <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_illegal   <= 1'b0;
    end else begin
      ex_rs1_data  <= id_rs1_data;
      ex_rs2_data  <= id_rs2_data;
      ex_imm       <= id_imm;
      ex_rd        <= id_rd;
      ex_alu_op    <= id_alu_op;
      ex_use_imm   <= id_use_imm;
      ex_reg_write <= id_reg_write;
      ex_illegal   <= id_illegal; // Rides along to writeback.
    end
  end

  // Decoder never pairs a write with ALU_NOP.
  nop_never_writes: assert property (@(posedge clock) disable iff (rst)
    (ex_alu_op == ALU_NOP) |-> !ex_reg_write);

endmodule

/* logic/execute_unit.sv */
`timescale 1ns/10ps
`include "pipe_defs.svh"

module execute_unit (
  input  logic                      clock,
  input  logic                      rst,
  input  logic [`PIPE_XLEN-1:0]     ex_rs1_data,
  input  logic [`PIPE_XLEN-1:0]     ex_rs2_data,
  input  logic [`PIPE_XLEN-1:0]     ex_imm,
  input  logic [`PIPE_REG_BITS-1:0] ex_rd,
  input  pipe_pkg::alu_op_e         ex_alu_op,
  input  logic                      ex_use_imm,
  input  logic                      ex_reg_write,
  input  logic                      ex_illegal,
  output logic                      wb_valid,
  output logic                      wb_illegal,
  output logic [`PIPE_REG_BITS-1:0] wb_rd,
  output logic [`PIPE_XLEN-1:0]     wb_data
);
  import pipe_pkg::*;

  logic [`PIPE_XLEN-1:0] op_a;
  logic [`PIPE_XLEN-1:0] op_b;
  logic [4:0]            shamt;
  logic [`PIPE_XLEN-1:0] alu_result;

  // ##########################################################
  // ALU
  // ##########################################################

  assign op_a  = ex_rs1_data;
  assign op_b  = ex_use_imm ? ex_imm : ex_rs2_data;
  assign shamt = op_b[4:0]; // Low five bits only.

  always_comb begin
    case (ex_alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // ##########################################################
  // EX/WB result register
  // ##########################################################

  always_ff @(posedge clock) begin
    if (rst) begin
      wb_valid   <= 1'b0;
      wb_illegal <= 1'b0;
    end else begin
      wb_valid   <= ex_reg_write && !ex_illegal;
      wb_illegal <= ex_illegal;
    end
  end

  always_ff @(posedge clock) begin
    wb_rd   <= ex_reg_write ? ex_rd : '0;
    wb_data <= ex_illegal ? '0 : alu_result; // Zero on illegal.
  end

  // Issues are spaced by the handshake, so writebacks never abut.
  wb_single_pulse: assert property (@(posedge clock) disable iff (rst)
    (wb_valid || wb_illegal) |=> !(wb_valid || wb_illegal));

endmodule

/* logic/int_pipe_top.sv */
`timescale 1ns/10ps
`include "pipe_defs.svh"

module int_pipe_top (
  input  logic                      clock,
  input  logic                      rst,
  input  logic                      instr_req,
  input  logic [`PIPE_XLEN-1:0]     instr,
  output logic                      instr_ack,
  output logic                      wb_valid,
  output logic [`PIPE_REG_BITS-1:0] wb_rd,
  output logic [`PIPE_XLEN-1:0]     wb_data,
  output logic                      wb_illegal
);
  import pipe_pkg::*;

  // Decode side.
  logic [`PIPE_XLEN-1:0]     held_instr;
  logic                      issue_valid;
  logic [`PIPE_REG_BITS-1:0] rs1, rs2, rd;
  logic [`PIPE_XLEN-1:0]     imm;
  alu_op_e                   alu_op;
  logic                      use_imm, reg_write, illegal;
  logic [`PIPE_XLEN-1:0]     rs1_data, rs2_data;

  // Execute side.
  logic [`PIPE_XLEN-1:0]     ex_rs1_data, ex_rs2_data, ex_imm;
  logic [`PIPE_REG_BITS-1:0] ex_rd;
  alu_op_e                   ex_alu_op;
  logic                      ex_use_imm, ex_reg_write, ex_illegal;

  pipeline_control u_ctrl (
    .clock, .rst, .instr_req, .instr, .instr_ack, .held_instr, .issue_valid
  );

  instr_decoder u_dec (
    .instr(held_instr), .rs1, .rs2, .rd, .imm, .alu_op, .use_imm, .reg_write, .illegal
  );

  register_file u_rf (
    .clock, .rst, .rs1, .rs2, .rs1_data, .rs2_data,
    .wr_en(wb_valid), .wr_addr(wb_rd), .wr_data(wb_data)
  );

  id_ex_stage_reg u_idex (
    .clock, .rst, .issue_valid,
    .id_rs1_data(rs1_data), .id_rs2_data(rs2_data), .id_imm(imm), .id_rd(rd),
    .id_alu_op(alu_op), .id_use_imm(use_imm), .id_reg_write(reg_write),
    .id_illegal(illegal),
    .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_rd, .ex_alu_op, .ex_use_imm,
    .ex_reg_write, .ex_illegal
  );

  execute_unit u_ex (
    .clock, .rst, .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_rd, .ex_alu_op,
    .ex_use_imm, .ex_reg_write, .ex_illegal, .wb_valid, .wb_illegal, .wb_rd, .wb_data
  );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int HALF_NS      = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic clock,
  output logic rst
);

  initial begin
    clock = 1'b0;
    forever #(HALF_NS) clock = ~clock;
  end

  initial begin
    rst = 1'b1; // Held over the first edges.
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    rst = 1'b0;
  end

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/10ps
`include "pipe_defs.svh"

module tb_checker (
  input  logic        clock,
  input  logic        rst,
  input  logic        instr_req,
  input  logic [31:0] instr,
  input  logic        instr_ack,
  input  logic        wb_valid,
  input  logic [4:0]  wb_rd,
  input  logic [31:0] wb_data,
  input  logic        wb_illegal,
  output int          error_count,
  output int          retired_count,
  output int          pending_count
);

  logic [31:0] shadow [32];
  logic        prev_ack = 1'b0;
  logic        prev_req = 1'b0;
  logic        prev_rst = 1'b0;
  int          cycle = 0;
  int          due_q [$];
  logic [31:0] word_q [$];
  logic [31:0] data_q [$];

  // ##########################################################
  // RV32I reference
  // ##########################################################

  function automatic bit is_supported(input logic [31:0] w);
    case (w[6:0])
      `OPC_LUI:    return 1'b1;
      `OPC_OP:     return w[31:25] == 7'b0 || (w[31:25] == 7'b0100000 &&
                          (w[14:12] == `F3_ADD || w[14:12] == `F3_SR));
      `OPC_OP_IMM: case (w[14:12])
          `F3_SLTU: return 1'b0; // No SLTIU in this slice.
          `F3_SLL:  return w[31:25] == 7'b0;
          `F3_SR:   return w[31:25] == 7'b0 || w[31:25] == 7'b0100000;
          default:  return 1'b1;
        endcase
      default:     return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_reference(input logic [31:0] w, input logic [31:0] a,
                                                input logic [31:0] rb);
    logic [31:0] b;
    logic        sub;
    if (w[6:0] == `OPC_LUI) return {w[31:12], 12'b0};
    b   = (w[6:0] == `OPC_OP) ? rb : {{20{w[31]}}, w[31:20]};
    sub = (w[6:0] == `OPC_OP) && w[30]; // ADDI has no subtract form.
    case (w[14:12])
      `F3_ADD:  return sub ? a - b : a + b;
      `F3_SLL:  return a << b[4:0];
      `F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
      `F3_SLTU: return {31'b0, a < b};
      `F3_XOR:  return a ^ b;
      `F3_SR:   return w[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      `F3_OR:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("failure at %0t: %s", $time, what);
    error_count++;
  endtask

  always @(posedge clock) begin
    logic [31:0] w;
    logic [31:0] exp_data;
    bit          legal;
    if (rst) begin
      for (int i = 0; i < 32; i++) shadow[i] = '0;
      due_q.delete();
      word_q.delete();
      data_q.delete();
      prev_ack = 1'b0;
      prev_req = 1'b0;
    end else begin
      cycle++;
      if (prev_rst && (instr_ack || wb_valid || wb_illegal))
        report_failure("outputs were not low after reset");
      if (instr_ack && !prev_ack && !prev_req)
        report_failure("instr_ack rose while instr_req was low");
      if (!instr_ack && prev_ack && prev_req)
        report_failure("instr_ack fell while instr_req was high");
      if (instr_ack && !prev_ack) begin // Issue edge was the previous one.
        w        = instr;
        legal    = is_supported(w);
        exp_data = legal ? alu_reference(w, shadow[w[19:15]], shadow[w[24:20]]) : '0;
        if (legal && w[11:7] != 5'd0) shadow[w[11:7]] = exp_data;
        due_q.push_back(cycle + 2);
        word_q.push_back(w);
        data_q.push_back(exp_data);
      end
      if (wb_valid || wb_illegal) begin
        if (due_q.size() == 0) begin
          report_failure("writeback seen with no instruction outstanding");
        end else begin
          w        = word_q.pop_front();
          exp_data = data_q.pop_front();
          legal    = is_supported(w);
          if (due_q.pop_front() != cycle)
            report_failure("writeback did not come 2 cycles after issue");
          if (wb_valid !== legal) report_mismatch("wb_valid", legal, wb_valid);
          if (wb_illegal !== !legal) report_mismatch("wb_illegal", !legal, wb_illegal);
          if (legal && wb_rd !== w[11:7]) report_mismatch("wb_rd", w[11:7], wb_rd);
          if (wb_data !== exp_data) report_mismatch("wb_data", exp_data, wb_data);
          retired_count++;
        end
      end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
        report_failure("no writeback for an issued instruction");
        void'(due_q.pop_front());
        void'(word_q.pop_front());
        void'(data_q.pop_front());
      end
      prev_ack      = instr_ack;
      prev_req      = instr_req;
      pending_count = due_q.size();
    end
    prev_rst = rst;
  end

endmodule

/* tests/tb_int_pipe.sv */
`timescale 1ns/10ps
`include "pipe_defs.svh"

module tb_int_pipe;

  localparam int CLOCK_NS     = 8;
  localparam int MAX_ISSUES   = 400;
  localparam int TIMEOUT_NS   = MAX_ISSUES * 10 * CLOCK_NS;
  localparam int RANDOM_COUNT = 300;

  logic        clock;
  logic        rst;
  logic        instr_req;
  logic [31:0] instr;
  logic        instr_ack;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        wb_illegal;
  int          error_count;
  int          retired_count;
  int          pending_count;
  int          issued;
  int          total_errors;
  int unsigned seed_ack;

  tb_clock_gen #(.HALF_NS(CLOCK_NS / 2), .RESET_CYCLES(3)) clk0 (.clock, .rst);

  int_pipe_top dut0 (
    .clock, .rst, .instr_req, .instr, .instr_ack, .wb_valid, .wb_rd, .wb_data, .wb_illegal
  );

  tb_checker chk0 (
    .clock, .rst, .instr_req, .instr, .instr_ack, .wb_valid, .wb_rd, .wb_data, .wb_illegal,
    .error_count, .retired_count, .pending_count
  );

  function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, `OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] lui_op(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, `OPC_LUI};
  endfunction

  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [31:0] u;
    logic [11:0] imm;
    logic [2:0]  f3;
    int unsigned kind;
    r    = $urandom();
    u    = $urandom();
    f3   = r[14:12];
    imm  = u[11:0];
    kind = r[20:16] % 20;
    if (kind == 0) return u; // Mostly undecodable.
    if (kind < 9) begin
      return reg_op((r[15] && (f3 == `F3_ADD || f3 == `F3_SR)) ? 7'b0100000 : 7'b0,
                    f3, {1'b0, r[3:0]}, {1'b0, r[7:4]}, {1'b0, r[11:8]});
    end
    if (kind < 18) begin
      if (f3 == `F3_SLL || f3 == `F3_SR) imm[11:5] = (r[15] && f3 == `F3_SR) ? 7'h20 : 7'h00;
      return imm_op(f3, {1'b0, r[3:0]}, {1'b0, r[7:4]}, imm);
    end
    return lui_op({1'b0, r[3:0]}, u[31:12]);
  endfunction

  // Four-phase issue of one word, with idle cycles before req and req held after ack.
  task automatic issue_spaced(input logic [31:0] word, input int unsigned gap,
                              input int unsigned hold);
    repeat (gap) begin
      @(posedge clock);
      #1;
    end
    instr     = word;
    instr_req = 1'b1;
    do begin
      @(posedge clock);
      #1;
    end while (!instr_ack);
    repeat (hold) begin
      @(posedge clock);
      #1;
    end
    instr_req = 1'b0;
    do begin
      @(posedge clock);
      #1;
    end while (instr_ack);
    issued++;
  endtask

  // Back to back, as fast as the handshake allows.
  task automatic issue(input logic [31:0] word);
    issue_spaced(word, 0, 0);
  endtask

  task automatic run_directed();
    issue(reg_op(7'b0, `F3_ADD, 5'd1, 5'd2, 5'd3)); // First reads after reset.
    issue(imm_op(`F3_ADD, 5'd1, 5'd0, 12'hfff));
    issue(imm_op(`F3_ADD, 5'd2, 5'd0, 12'h005));
    issue(lui_op(5'd3, 20'h80000));
    issue(reg_op(7'b0, `F3_SLT, 5'd4, 5'd1, 5'd2));
    issue(reg_op(7'b0, `F3_SLTU, 5'd5, 5'd1, 5'd2));
    issue(imm_op(`F3_SLT, 5'd6, 5'd1, 12'h000));
    issue(reg_op(7'b0100000, `F3_SR, 5'd7, 5'd3, 5'd2)); // SRA.
    issue(reg_op(7'b0, `F3_SR, 5'd8, 5'd3, 5'd2));
    issue(imm_op(`F3_SR, 5'd9, 5'd3, 12'h41f)); // SRAI by 31.
    issue(reg_op(7'b0, `F3_SLL, 5'd10, 5'd2, 5'd2));
    issue(reg_op(7'b0100000, `F3_ADD, 5'd11, 5'd2, 5'd1)); // SUB.
    issue(reg_op(7'b0, `F3_XOR, 5'd12, 5'd1, 5'd3));
    issue(reg_op(7'b0, `F3_OR, 5'd12, 5'd12, 5'd2));
    issue(reg_op(7'b0, `F3_AND, 5'd12, 5'd12, 5'd11));
    issue(imm_op(`F3_XOR, 5'd13, 5'd2, 12'h800));
    issue(imm_op(`F3_OR, 5'd13, 5'd13, 12'h0f0));
    issue(imm_op(`F3_AND, 5'd13, 5'd13, 12'hf0f));
    issue(imm_op(`F3_SLL, 5'd14, 5'd2, 12'h01c));
    issue(imm_op(`F3_SR, 5'd14, 5'd14, 12'h004));
    for (int i = 0; i < 4; i++) issue(imm_op(`F3_ADD, 5'd15, 5'd15, 12'h7ff));
    issue(imm_op(`F3_ADD, 5'd0, 5'd2, 12'h007)); // Lost in x0.
    issue(reg_op(7'b0, `F3_ADD, 5'd16, 5'd0, 5'd2));
    issue(reg_op(7'b0000001, `F3_ADD, 5'd2, 5'd2, 5'd2)); // MUL, not decoded.
    issue(imm_op(`F3_SLTU, 5'd2, 5'd2, 12'h001));
    issue(32'hffffffff);
    issue(reg_op(7'b0, `F3_OR, 5'd17, 5'd2, 5'd0)); // x2 must be unchanged.
  endtask

  task automatic run_random();
    logic [31:0] word;
    int unsigned gap;
    int unsigned hold;
    repeat (RANDOM_COUNT) begin
      word = random_instr();
      gap  = $urandom() % 3;
      hold = $urandom() % 3; // Req stays up past ack.
      issue_spaced(word, gap, hold);
    end
  endtask

  initial begin
    instr_req = 1'b0;
    instr     = '0;
    issued    = 0;
    seed_ack  = $urandom(32'hb321b9f7);
    do begin
      @(posedge clock);
    end while (rst !== 1'b0);
    #1;
    run_directed();
    run_random();
    while (pending_count != 0) begin
      @(posedge clock);
      #1;
    end
    total_errors = error_count;
    if (retired_count != issued) begin
      $display("issued %0d instructions but %0d wrote back", issued, retired_count);
      total_errors++;
    end
    $display("errors: %0d, instructions issued: %0d", total_errors, issued);
    if (total_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("errors: %0d, instructions issued: %0d", error_count + 1, issued);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
logic/pipe_pkg.sv
logic/pipeline_control.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/id_ex_stage_reg.sv
logic/execute_unit.sv
logic/int_pipe_top.sv
tests/tb_clock_gen.sv
tests/tb_checker.sv
tests/tb_int_pipe.sv

/* Bender.yml */
package:
  name: int_pipe

sources:
  - include_dirs:
      - include
    files:
      - logic/pipe_pkg.sv
      - logic/pipeline_control.sv
      - logic/instr_decoder.sv
      - logic/register_file.sv
      - logic/id_ex_stage_reg.sv
      - logic/execute_unit.sv
      - logic/int_pipe_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_checker.sv
      - tests/tb_int_pipe.sv
